/* Bender.yml */
package:
  name: fir17

sources:
  - fir17_pkg.sv
  - coef_bank.sv
  - sample_fifo.sv
  - fir_sym17.sv
  - fir17_top.sv
  - target: simulation
    files:
      - tb_fir17.sv

/* coef_bank.sv */
`default_nettype none

module coef_bank (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   coef_we,
	input  wire fir17_pkg::coef_addr_t coef_addr,
	input  wire fir17_pkg::coef_t coef_data,
	output fir17_pkg::coef_t      coef_0,
	output fir17_pkg::coef_t      coef_1,
	output fir17_pkg::coef_t      coef_2,
	output fir17_pkg::coef_t      coef_3,
	output fir17_pkg::coef_t      coef_4,
	output fir17_pkg::coef_t      coef_5,
	output fir17_pkg::coef_t      coef_6,
	output fir17_pkg::coef_t      coef_7,
	output fir17_pkg::coef_t      coef_8
);

	import fir17_pkg::*;

	// one register per folded coefficient
	coef_t coef_r [NUM_COEFS];

	// address decode, one write per cycle
	// no entry matches addresses 9 to 15, so those writes are dropped
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_COEFS; i++) begin
				coef_r[i] <= '0;
			end
		end else if (coef_we) begin
			for (int i = 0; i < NUM_COEFS; i++) begin
				if (coef_addr == coef_addr_t'(i)) begin
					coef_r[i] <= coef_data;
				end
			end
		end
	end

	// registers go straight out to the filter
	assign coef_0 = coef_r[0];
	assign coef_1 = coef_r[1];
	assign coef_2 = coef_r[2];
	assign coef_3 = coef_r[3];
	assign coef_4 = coef_r[4];
	assign coef_5 = coef_r[5];
	assign coef_6 = coef_r[6];
	assign coef_7 = coef_r[7];
	// centre tap coefficient
	assign coef_8 = coef_r[8];

endmodule

`default_nettype wire

/* fir17.f */
fir17_pkg.sv
coef_bank.sv
sample_fifo.sv
fir_sym17.sv
fir17_top.sv
tb_fir17.sv

/* fir17_pkg.sv */
`default_nettype none

package fir17_pkg;

	// sample width, both input and filtered output
	localparam int unsigned SAMPLE_W = 20;

	// coefficient width
	localparam int unsigned COEF_W = 16;

	// product and running sum width
	// the output sample is the top SAMPLE_W bits of this word
	localparam int unsigned ACC_W = 40;

	// full delay line length
	localparam int unsigned NUM_TAPS = 17;

	// folded coefficient count
	// eight pair coefficients plus the centre tap coefficient
	localparam int unsigned NUM_COEFS = 9;

	// coefficient write address width
	// addresses NUM_COEFS and above are ignored by the bank
	localparam int unsigned COEF_ADDR_W = 4;

	// default input FIFO depth
	localparam int unsigned FIFO_DEPTH = 4;

	// one unsigned sample
	typedef logic [SAMPLE_W-1:0] sample_t;

	// one unsigned coefficient
	typedef logic [COEF_W-1:0] coef_t;

	// product and sum word, wraps modulo 2^ACC_W
	typedef logic [ACC_W-1:0] acc_t;

	// coefficient index
	typedef logic [COEF_ADDR_W-1:0] coef_addr_t;

endpackage

`default_nettype wire

/* fir17_top.sv */
`default_nettype none

module fir17_top (
	input  wire                        clk,
	input  wire                        rst_n,
	// sample stream in
	input  wire                        in_valid,
	input  wire fir17_pkg::sample_t    in_data,
	output logic                       in_ready,
	// coefficient write port, no handshake
	input  wire                        coef_we,
	input  wire fir17_pkg::coef_addr_t coef_addr,
	input  wire fir17_pkg::coef_t      coef_data,
	// filtered stream out
	output logic                       out_valid,
	output fir17_pkg::sample_t         out_data,
	input  wire                        out_ready
);

	import fir17_pkg::*;

	// FIFO to filter
	logic    fifo_valid;
	sample_t fifo_data;
	logic    fifo_ready;

	// bank to filter
	coef_t coef_0;
	coef_t coef_1;
	coef_t coef_2;
	coef_t coef_3;
	coef_t coef_4;
	coef_t coef_5;
	coef_t coef_6;
	coef_t coef_7;
	coef_t coef_8;

	coef_bank u_coef_bank (
		.clk       (clk),
		.rst_n     (rst_n),
		.coef_we   (coef_we),
		.coef_addr (coef_addr),
		.coef_data (coef_data),
		.coef_0    (coef_0),
		.coef_1    (coef_1),
		.coef_2    (coef_2),
		.coef_3    (coef_3),
		.coef_4    (coef_4),
		.coef_5    (coef_5),
		.coef_6    (coef_6),
		.coef_7    (coef_7),
		.coef_8    (coef_8)
	);

	// absorbs input bursts while the filter is stalled
	sample_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_valid (in_valid),
		.wr_data  (in_data),
		.wr_ready (in_ready),
		.rd_valid (fifo_valid),
		.rd_data  (fifo_data),
		.rd_ready (fifo_ready)
	);

	fir_sym17 u_fir (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (fifo_valid),
		.in_data   (fifo_data),
		.in_ready  (fifo_ready),
		.coef_0    (coef_0),
		.coef_1    (coef_1),
		.coef_2    (coef_2),
		.coef_3    (coef_3),
		.coef_4    (coef_4),
		.coef_5    (coef_5),
		.coef_6    (coef_6),
		.coef_7    (coef_7),
		.coef_8    (coef_8),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

/* fir_sym17.sv */
`default_nettype none

module fir_sym17 (
	input  wire                     clk,
	input  wire                     rst_n,
	// sample input, popped from the FIFO
	input  wire                     in_valid,
	input  wire fir17_pkg::sample_t in_data,
	output logic                    in_ready,
	// folded coefficients
	input  wire fir17_pkg::coef_t   coef_0,
	input  wire fir17_pkg::coef_t   coef_1,
	input  wire fir17_pkg::coef_t   coef_2,
	input  wire fir17_pkg::coef_t   coef_3,
	input  wire fir17_pkg::coef_t   coef_4,
	input  wire fir17_pkg::coef_t   coef_5,
	input  wire fir17_pkg::coef_t   coef_6,
	input  wire fir17_pkg::coef_t   coef_7,
	input  wire fir17_pkg::coef_t   coef_8,
	// filtered output
	output logic                    out_valid,
	output fir17_pkg::sample_t      out_data,
	input  wire                     out_ready
);

	import fir17_pkg::*;

	// global stage enable
	// the whole pipe advances when the output slot is free or being taken
	logic en;

	// sample handshake on the input side
	logic accept;

	// delay line, taps[0] is the newest accepted sample
	sample_t taps [NUM_TAPS];

	// set after an accepted sample, marks the taps as a fresh window
	logic tap_valid;

	// coefficients gathered into an array for the loops below
	coef_t coef_w [NUM_COEFS];

	// pre-add results for the eight symmetric pairs
	acc_t pair_sum [NUM_COEFS-1];

	// products before and after the first stage register
	acc_t prod_d [NUM_COEFS];
	acc_t prod_q [NUM_COEFS];
	logic prod_valid;

	// running sum of registered products
	acc_t sum;

	assign en       = !out_valid || out_ready;
	assign in_ready = en;
	assign accept   = in_valid && en;

	assign coef_w[0] = coef_0;
	assign coef_w[1] = coef_1;
	assign coef_w[2] = coef_2;
	assign coef_w[3] = coef_3;
	assign coef_w[4] = coef_4;
	assign coef_w[5] = coef_5;
	assign coef_w[6] = coef_6;
	assign coef_w[7] = coef_7;
	assign coef_w[8] = coef_8;

	// delay line shifts only on an accepted sample
	// a stalled or idle cycle leaves the history untouched
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_TAPS; i++) begin
				taps[i] <= '0;
			end
			tap_valid <= 1'b0;
		end else if (en) begin
			tap_valid <= accept;
			if (accept) begin
				taps[0] <= in_data;
				for (int i = 1; i < NUM_TAPS; i++) begin
					taps[i] <= taps[i-1];
				end
			end
		end
	end

	// pre-add of mirrored taps, then multiply
	// pair sums are widened first so the carry is kept
	always_comb begin
		for (int i = 0; i < NUM_COEFS - 1; i++) begin
			pair_sum[i] = acc_t'(taps[i]) + acc_t'(taps[NUM_TAPS-1-i]);
			prod_d[i]   = pair_sum[i] * acc_t'(coef_w[i]);
		end
		// centre tap has no partner
		prod_d[NUM_COEFS-1] = acc_t'(taps[NUM_COEFS-1]) * acc_t'(coef_w[NUM_COEFS-1]);
	end

	// stage 1, product registers
	// coefficients are sampled here, on the enabled edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_COEFS; i++) begin
				prod_q[i] <= '0;
			end
			prod_valid <= 1'b0;
		end else if (en) begin
			prod_q     <= prod_d;
			prod_valid <= tap_valid;
		end
	end

	// adder chain, wraps modulo 2^ACC_W
	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_COEFS; i++) begin
			sum = sum + prod_q[i];
		end
	end

	// stage 2, output valid
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (en) begin
			out_valid <= prod_valid;
		end
	end

	// stage 2, output word is the top of the sum
	// only loaded for a real sample, so it holds through bubbles and stalls
	always_ff @(posedge clk) begin
		if (en && prod_valid) begin
			out_data <= sum[ACC_W-1 -: SAMPLE_W];
		end
	end

endmodule

`default_nettype wire

/* sample_fifo.sv */
`default_nettype none

module sample_fifo #(
	parameter int unsigned DEPTH = fir17_pkg::FIFO_DEPTH
) (
	input  wire                     clk,
	input  wire                     rst_n,
	// write side
	input  wire                     wr_valid,
	input  wire fir17_pkg::sample_t wr_data,
	output logic                    wr_ready,
	// read side
	output logic                    rd_valid,
	output fir17_pkg::sample_t      rd_data,
	input  wire                     rd_ready
);

	import fir17_pkg::*;

	// circular storage, payload only
	sample_t mem [DEPTH];

	// pointers wrap at DEPTH, so any depth of 2 or more works
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;

	// occupancy, 0 to DEPTH inclusive
	logic [$clog2(DEPTH+1)-1:0] count;

	logic push;
	logic pop;

	// flags come from the count only
	assign wr_ready = (count != DEPTH);
	assign rd_valid = (count != 0);

	// oldest word is always at the read pointer
	assign rd_data = mem[rd_ptr];

	assign push = wr_valid && wr_ready;
	assign pop  = rd_valid && rd_ready;

	// storage write
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// pointer and count update
	// push and pop in the same cycle leave the count unchanged
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				if (int'(wr_ptr) == DEPTH - 1) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop) begin
				if (int'(rd_ptr) == DEPTH - 1) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* tb_fir17.sv */
`default_nettype none

module tb_fir17;

	timeunit 1ns;
	timeprecision 1ps;

	import fir17_pkg::*;

	// burst lengths per test
	localparam int N_IMPULSE = 20;
	localparam int N_RANDOM  = 60;
	localparam int N_BP      = 60;
	localparam int N_RELOAD  = 30;
	localparam int N_IGNORE  = 20;
	localparam int N_PRE_RST = 5;
	localparam int N_POST    = 20;
	localparam int TOTAL_SAMPLES = N_IMPULSE + N_RANDOM + N_BP + N_RELOAD + N_IGNORE
		+ N_PRE_RST + N_POST;
	localparam int TIMEOUT_CYCLES = 8 * TOTAL_SAMPLES + 200;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	sample_t    in_data;
	logic       in_ready;
	logic       coef_we;
	coef_addr_t coef_addr;
	coef_t      coef_data;
	logic       out_valid;
	sample_t    out_data;
	logic       out_ready;

	// model state, history newest first
	sample_t hist [NUM_TAPS];
	coef_t   mcoef [NUM_COEFS];
	sample_t expq [$];

	logic [15:0] stim_lfsr = 16'd37;
	logic [15:0] rdy_lfsr  = 16'd37;
	logic        bp_mode;
	logic        stalled;
	sample_t     held_data;
	int          cycle_count = 0;

	fir17_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.coef_we   (coef_we),
		.coef_addr (coef_addr),
		.coef_data (coef_data),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// reference: folded 17-tap sum mod 2^40, top 20 bits out
	function automatic sample_t fir_model();
		acc_t acc;
		acc = '0;
		for (int i = 0; i < 8; i++) begin
			acc = acc + (acc_t'(hist[i]) + acc_t'(hist[16-i])) * acc_t'(mcoef[i]);
		end
		acc = acc + acc_t'(hist[8]) * acc_t'(mcoef[8]);
		return acc[39:20];
	endfunction

	task automatic report_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_sample(input string name, input sample_t actual, input sample_t expected);
		if (actual !== expected) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			report_failure();
		end
	endtask

	// all driver tasks start and end 1 ns after a rising edge
	task automatic apply_reset();
		rst_n = 1'b0;
		for (int i = 0; i < NUM_TAPS; i++) begin
			hist[i] = '0;
		end
		for (int i = 0; i < NUM_COEFS; i++) begin
			mcoef[i] = '0;
		end
		expq.delete();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	// model ignores the same addresses as the bank
	task automatic write_coef(input coef_addr_t addr, input coef_t data);
		coef_we   = 1'b1;
		coef_addr = addr;
		coef_data = data;
		@(posedge clk);
		#1;
		coef_we = 1'b0;
		if (addr < NUM_COEFS) begin
			mcoef[addr] = data;
		end
	endtask

	task automatic load_random_coefs();
		for (int i = 0; i < NUM_COEFS; i++) begin
			write_coef(coef_addr_t'(i), coef_t'(rand_bits(COEF_W)));
		end
	endtask

	// in_ready only moves on an edge, so the value seen here holds for the next one
	task automatic send_sample(input sample_t s);
		logic ready_seen;
		in_valid = 1'b1;
		in_data  = s;
		do begin
			ready_seen = in_ready;
			@(posedge clk);
			#1;
		end while (!ready_seen);
	endtask

	task automatic send_burst(input int n, input logic gaps);
		int gap;
		for (int k = 0; k < n; k++) begin
			send_sample(sample_t'(rand_bits(SAMPLE_W)));
			if (gaps) begin
				gap = int'(rand_bits(2));
				if (gap != 0) begin
					in_valid = 1'b0;
					repeat (gap) @(posedge clk);
					#1;
				end
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (expq.size() != 0) begin
			@(posedge clk);
			#1;
		end
		repeat (2) @(posedge clk);
		#1;
	endtask

	// out_ready pattern, random under back-pressure
	// mode is taken at the edge, the new level goes out 1 ns later
	always @(posedge clk) begin
		if (bp_mode) begin
			rdy_lfsr = lfsr_next(rdy_lfsr);
			#1;
			out_ready = rdy_lfsr[0];
		end else begin
			#1;
			out_ready = 1'b1;
		end
	end

	// compare first, then queue the expected word for this edge's input
	always @(posedge clk) begin
		if (!rst_n) begin
			stalled = 1'b0;
		end else begin
			// a stalled word must stay put until taken
			if (stalled) begin
				check_flag("out_valid", out_valid, 1'b1);
				check_sample("out_data", out_data, held_data);
			end
			if (out_valid && out_ready) begin
				if (expq.size() == 0) begin
					$display("output sample arrived with no accepted input left to match it");
					report_failure();
				end else begin
					check_sample("out_data", out_data, expq.pop_front());
				end
			end
			stalled   = out_valid && !out_ready;
			held_data = out_data;
			if (in_valid && in_ready) begin
				for (int i = NUM_TAPS - 1; i > 0; i--) begin
					hist[i] = hist[i-1];
				end
				hist[0] = in_data;
				expq.push_back(fir_model());
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, output stream stalled after %0d cycles", cycle_count);
			report_failure();
		end
	end

	initial begin
		in_valid  = 1'b0;
		in_data   = '0;
		coef_we   = 1'b0;
		coef_addr = '0;
		coef_data = '0;
		out_ready = 1'b1;
		bp_mode   = 1'b0;
		stalled   = 1'b0;
		held_data = '0;
		apply_reset();

		// impulse, coefficients 0x100 * (index + 1)
		for (int i = 0; i < NUM_COEFS; i++) begin
			write_coef(coef_addr_t'(i), coef_t'(16'h0100 * (i + 1)));
		end
		send_sample(sample_t'(20'h80000));
		for (int k = 1; k < N_IMPULSE; k++) begin
			send_sample('0);
		end
		in_valid = 1'b0;
		wait_drained();

		// random stream, output always ready
		load_random_coefs();
		send_burst(N_RANDOM, 1'b1);
		wait_drained();

		// back-pressure
		bp_mode = 1'b1;
		send_burst(N_BP, 1'b1);
		wait_drained();
		bp_mode = 1'b0;

		// reload, history from the earlier bursts carries over
		load_random_coefs();
		send_burst(N_RELOAD, 1'b0);
		wait_drained();

		// out of range addresses are dropped
		for (int a = NUM_COEFS; a < 16; a++) begin
			write_coef(coef_addr_t'(a), coef_t'(rand_bits(COEF_W)));
		end
		send_burst(N_IGNORE, 1'b1);
		wait_drained();

		// reset with samples still in flight
		send_burst(N_PRE_RST, 1'b0);
		apply_reset();
		check_flag("in_ready", in_ready, 1'b1);
		repeat (5) begin
			check_flag("out_valid", out_valid, 1'b0);
			@(posedge clk);
			#1;
		end
		// odd coefficients keep their reset value of zero
		for (int i = 0; i < NUM_COEFS; i += 2) begin
			write_coef(coef_addr_t'(i), coef_t'(rand_bits(COEF_W)));
		end
		send_burst(N_POST, 1'b1);
		wait_drained();

		if (!out_valid) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("output still valid after the last expected sample was taken");
			report_failure();
		end
	end

endmodule

`default_nettype wire
